// ==== source/npc_pkg.sv ====
package npc_pkg;

    // *************************************************************************
    // Jump kinds from decode and execute.
    // *************************************************************************

    typedef enum logic [2:0] {
        NOT_JUMP      = 3'd0,
        DIRECT_JUMP   = 3'd1,
        JUMP          = 3'd2,
        CALL          = 3'd3,
        RET           = 3'd4,
        INDIRECT_JUMP = 3'd5,
        OTHER_JUMP    = 3'd6
    } jump_kind_e;  // 3'd7 is illegal, seen as NOT_JUMP.

    // True for any legal kind other than NOT_JUMP.
    function automatic logic is_jump(jump_kind_e kind);
        return (kind != NOT_JUMP) && (kind <= OTHER_JUMP);
    endfunction

    // *************************************************************************
    // BTB versus RAS choice counters.
    // *************************************************************************

    typedef logic [1:0] choice_ctr_t;  // MSB set picks the RAS.

    localparam choice_ctr_t CHOICE_RESET = 2'b01;  // Weakly BTB.

    // *************************************************************************
    // Top-level parameter defaults.
    // *************************************************************************

    localparam int DEFAULT_GH_WIDTH   = 8;
    localparam int DEFAULT_STACK_LEN  = 16;
    localparam int DEFAULT_ADDR_WIDTH = 29;

endpackage

// ==== source/ex_update_if.sv ====
`timescale 1ns/1ns

// Resolution of one instruction at execute.
// kind_ex qualifies the whole bundle.
interface ex_update_if #(
    parameter int gh_width   = 8,
    parameter int addr_width = 29
);

    logic [addr_width-1:0] pc_ex;      // Resolved instruction address.
    logic [addr_width-1:0] npc_ex;     // Its actual next address.
    logic [gh_width-1:0]   hashed_ex;  // PC folded with history.
    npc_pkg::jump_kind_e   kind_ex;
    logic                  choice_real;  // RAS would have been right.

    modport src (
        output pc_ex,
        output npc_ex,
        output hashed_ex,
        output kind_ex,
        output choice_real
    );

    modport sink (
        input pc_ex,
        input npc_ex,
        input hashed_ex,
        input kind_ex,
        input choice_real
    );

endinterface

// ==== source/btb.sv ====
`timescale 1ns/1ns

module btb #(
    parameter int gh_width   = 8,
    parameter int addr_width = 29
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic [gh_width-1:0]   pc_hashed,
    ex_update_if.sink             ex,

    output logic [addr_width-1:0] target,
    output logic                  valid
);

    localparam int entries = 2 ** gh_width;

    logic [addr_width-1:0] targets [entries];
    logic [entries-1:0]    valid_q;
    logic                  wr_en;

    // *************************************************************************
    // Update from execute.
    // *************************************************************************

    // Any legal jump kind refreshes the entry.
    assign wr_en = npc_pkg::is_jump(ex.kind_ex);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            targets[ex.hashed_ex] <= ex.npc_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[ex.hashed_ex] <= 1'b1;
        end
    end

    // *************************************************************************
    // Lookup.
    // *************************************************************************

    assign target = targets[pc_hashed];
    assign valid  = valid_q[pc_hashed];  // Target is junk when clear.

endmodule

// ==== source/ras.sv ====
`timescale 1ns/1ns

module ras #(
    parameter int stack_len  = 16,
    parameter int addr_width = 29
) (
    input  logic                  clk,
    input  logic                  reset,

    ex_update_if.sink             ex,

    output logic [addr_width-1:0] top,
    output logic                  valid
);

    // Pointer needs at least one bit for a one-entry stack.
    localparam int ptr_w   = (stack_len > 1) ? $clog2(stack_len) : 1;
    localparam int depth_w = $clog2(stack_len + 1);

    localparam logic [ptr_w-1:0]   last_ptr   = ptr_w'(stack_len - 1);
    localparam logic [depth_w-1:0] full_depth = depth_w'(stack_len);

    logic [addr_width-1:0] stack [stack_len];

    logic [ptr_w-1:0]   top_ptr;  // Latest live push.
    logic [ptr_w-1:0]   ptr_inc;
    logic [ptr_w-1:0]   ptr_dec;
    logic [depth_w-1:0] depth;
    logic               push;
    logic               pop;

    // *************************************************************************
    // Push and pop decode.
    // *************************************************************************

    assign push = (ex.kind_ex == npc_pkg::CALL);
    assign pop  = (ex.kind_ex == npc_pkg::RET) && (depth != '0);  // Empty pop ignored.

    // Circular wrap, also for depths that are not a power of two.
    assign ptr_inc = (top_ptr == last_ptr) ? '0 : top_ptr + 1'b1;
    assign ptr_dec = (top_ptr == '0) ? last_ptr : top_ptr - 1'b1;

    // *************************************************************************
    // Storage.
    // *************************************************************************

    // On overflow this lands on the oldest entry.
    always_ff @(posedge clk) begin
        if (push) begin
            stack[ptr_inc] <= ex.pc_ex + 1'b1;  // Return address.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            top_ptr <= '0;
            depth   <= '0;
        end else if (push) begin
            top_ptr <= ptr_inc;
            if (depth != full_depth) begin
                depth <= depth + 1'b1;
            end
        end else if (pop) begin
            top_ptr <= ptr_dec;
            depth   <= depth - 1'b1;
        end
    end

    // *************************************************************************
    // Lookup.
    // *************************************************************************

    assign top   = stack[top_ptr];
    assign valid = (depth != '0);

endmodule

// ==== source/cpht.sv ====
`timescale 1ns/1ns

module cpht #(
    parameter int gh_width = 8
) (
    input  logic                clk,
    input  logic                reset,

    input  logic [gh_width-1:0] pc_hashed,
    ex_update_if.sink           ex,

    output logic                choice
);

    localparam int entries = 2 ** gh_width;

    npc_pkg::choice_ctr_t ctrs [entries];
    npc_pkg::choice_ctr_t cur;   // Entry under update.
    logic                 upd_en;

    // Only returns train the choice.
    assign upd_en = (ex.kind_ex == npc_pkg::RET);
    assign cur    = ctrs[ex.hashed_ex];

    // *************************************************************************
    // Saturating counter update.
    // *************************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < entries; i++) begin
                ctrs[i] <= npc_pkg::CHOICE_RESET;
            end
        end else if (upd_en) begin
            if (ex.choice_real) begin
                if (cur != 2'b11) begin
                    ctrs[ex.hashed_ex] <= cur + 1'b1;  // Toward RAS.
                end
            end else if (cur != 2'b00) begin
                ctrs[ex.hashed_ex] <= cur - 1'b1;      // Toward BTB.
            end
        end
    end

    // 0 picks the BTB, 1 the RAS.
    assign choice = ctrs[pc_hashed][1];

endmodule

// ==== source/npc_select.sv ====
`timescale 1ns/1ns

module npc_select #(
    parameter int addr_width = 29
) (
    input  logic [addr_width-1:0] pc,

    input  logic [addr_width-1:0] btb_target,
    input  logic                  btb_valid,
    input  logic [addr_width-1:0] ras_top,
    input  logic                  ras_valid,
    input  logic                  choice,

    input  npc_pkg::jump_kind_e   kind_pdc,
    input  logic                  taken_pdc,

    output logic [addr_width-1:0] npc_pdc
);

    logic [addr_width-1:0] seq_pc;
    logic [addr_width-1:0] src_target;
    logic                  src_valid;
    logic                  use_ras;

    assign seq_pc = pc + 1'b1;  // Fall-through.

    // *************************************************************************
    // Source choice.
    // *************************************************************************

    // Only returns may take the RAS.
    assign use_ras    = (kind_pdc == npc_pkg::RET) && choice;
    assign src_target = use_ras ? ras_top : btb_target;
    assign src_valid  = use_ras ? ras_valid : btb_valid;

    always_comb begin
        if (taken_pdc && npc_pkg::is_jump(kind_pdc) && src_valid) begin
            npc_pdc = src_target;
        end else begin
            npc_pdc = seq_pc;  // Not taken, no jump, or nothing stored.
        end
    end

endmodule

// ==== source/npc_predictor.sv ====
`timescale 1ns/1ns

module npc_predictor #(
    parameter int gh_width   = npc_pkg::DEFAULT_GH_WIDTH,
    parameter int stack_len  = npc_pkg::DEFAULT_STACK_LEN,
    parameter int addr_width = npc_pkg::DEFAULT_ADDR_WIDTH
) (
    input  logic                  clk,
    input  logic                  reset,

    // Resolution from execute.
    input  logic [addr_width-1:0] pc_ex,
    input  logic [addr_width-1:0] npc_ex,
    input  logic [gh_width-1:0]   hashed_ex,
    input  logic [2:0]            kind_ex,
    input  logic                  choice_real,

    // Lookup for fetch.
    input  logic [addr_width-1:0] pc,
    input  logic [gh_width-1:0]   pc_hashed,
    input  logic [2:0]            kind_pdc,
    input  logic                  taken_pdc,

    output logic [addr_width-1:0] npc_pdc,
    output logic                  choice_btb_ras  // 0 BTB, 1 RAS.
);

    ex_update_if #(
        .gh_width   (gh_width),
        .addr_width (addr_width)
    ) ex_bus ();

    logic [addr_width-1:0] btb_target;
    logic                  btb_valid;
    logic [addr_width-1:0] ras_top;
    logic                  ras_valid;

    // *************************************************************************
    // Execute-stage bundle.
    // *************************************************************************

    assign ex_bus.pc_ex       = pc_ex;
    assign ex_bus.npc_ex      = npc_ex;
    assign ex_bus.hashed_ex   = hashed_ex;
    assign ex_bus.kind_ex     = npc_pkg::jump_kind_e'(kind_ex);
    assign ex_bus.choice_real = choice_real;

    // *************************************************************************
    // Tables and select.
    // *************************************************************************

    btb #(
        .gh_width   (gh_width),
        .addr_width (addr_width)
    ) u_btb (
        .clk       (clk),
        .reset     (reset),
        .pc_hashed (pc_hashed),
        .ex        (ex_bus),
        .target    (btb_target),
        .valid     (btb_valid)
    );

    ras #(
        .stack_len  (stack_len),
        .addr_width (addr_width)
    ) u_ras (
        .clk   (clk),
        .reset (reset),
        .ex    (ex_bus),
        .top   (ras_top),
        .valid (ras_valid)
    );

    cpht #(
        .gh_width (gh_width)
    ) u_cpht (
        .clk       (clk),
        .reset     (reset),
        .pc_hashed (pc_hashed),
        .ex        (ex_bus),
        .choice    (choice_btb_ras)
    );

    npc_select #(
        .addr_width (addr_width)
    ) u_select (
        .pc         (pc),
        .btb_target (btb_target),
        .btb_valid  (btb_valid),
        .ras_top    (ras_top),
        .ras_valid  (ras_valid),
        .choice     (choice_btb_ras),
        .kind_pdc   (npc_pkg::jump_kind_e'(kind_pdc)),
        .taken_pdc  (taken_pdc),
        .npc_pdc    (npc_pdc)
    );

endmodule

// ==== sim/npc_predictor_properties.sv ====
`timescale 1ns/1ns

module npc_predictor_properties #(
    parameter int gh_width   = 8,
    parameter int addr_width = 29
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [2:0]            kind_ex,
    input  logic [addr_width-1:0] pc,
    input  logic [gh_width-1:0]   pc_hashed,
    input  logic [2:0]            kind_pdc,
    input  logic                  taken_pdc,
    input  logic [addr_width-1:0] npc_pdc,
    input  logic                  choice_btb_ras
);

    int unsigned fail_count = 0;  // Failed checks so far.

    logic [addr_width-1:0] seq_pc;
    logic                  no_jump;

    assign seq_pc  = pc + 1'b1;
    assign no_jump = (kind_pdc == npc_pkg::NOT_JUMP) || (kind_pdc == 3'd7);

    // *************************************************************************
    // Lookups that must fall through.
    // *************************************************************************

    // Freshly reset tables predict fall-through and the BTB.
    a_reset_state: assert property (@(posedge clk)
        reset |=> (npc_pdc == seq_pc) && !choice_btb_ras)
        else begin
            $error("Lookup after reset did not predict pc + 1 with the BTB chosen.");
            fail_count++;
        end

    a_not_taken: assert property (@(posedge clk) !taken_pdc |-> npc_pdc == seq_pc)
        else begin
            $error("Not-taken lookup did not predict pc + 1.");
            fail_count++;
        end

    a_no_jump: assert property (@(posedge clk) no_jump |-> npc_pdc == seq_pc)
        else begin
            $error("Lookup of a non-jump or illegal kind did not predict pc + 1.");
            fail_count++;
        end

    // *************************************************************************
    // Choice only moves on a resolved return.
    // *************************************************************************

    a_choice_steady: assert property (@(posedge clk)
        (!reset && kind_ex != npc_pkg::RET) ##1 $stable(pc_hashed)
            |-> $stable(choice_btb_ras))
        else begin
            $error("Choice changed without a return update.");
            fail_count++;
        end

endmodule

// ==== sim/npc_predictor_tb.sv ====
`timescale 1ns/1ns

module npc_predictor_tb;

    localparam int gh_width   = 4;
    localparam int stack_len  = 4;
    localparam int addr_width = 16;

    localparam int entries        = 2 ** gh_width;
    localparam int clk_period     = 100;
    localparam int reset_cycles   = 8;
    localparam int directed_steps = 28;
    localparam int random_steps   = 400;

    logic                  clk;
    logic                  reset;
    logic [addr_width-1:0] pc_ex;
    logic [addr_width-1:0] npc_ex;
    logic [gh_width-1:0]   hashed_ex;
    logic [2:0]            kind_ex;
    logic                  choice_real;
    logic [addr_width-1:0] pc;
    logic [gh_width-1:0]   pc_hashed;
    logic [2:0]            kind_pdc;
    logic                  taken_pdc;
    logic [addr_width-1:0] npc_pdc;
    logic                  choice_btb_ras;

    logic [31:0] rng_state;

    // Reference model of the three tables.
    logic [addr_width-1:0] model_tgt [entries];
    logic                  model_vld [entries];
    int                    model_ctr [entries];
    logic [addr_width-1:0] model_stack [$];  // Newest at the back.

    npc_predictor #(
        .gh_width   (gh_width),
        .stack_len  (stack_len),
        .addr_width (addr_width)
    ) dut (
        .clk            (clk),
        .reset          (reset),
        .pc_ex          (pc_ex),
        .npc_ex         (npc_ex),
        .hashed_ex      (hashed_ex),
        .kind_ex        (kind_ex),
        .choice_real    (choice_real),
        .pc             (pc),
        .pc_hashed      (pc_hashed),
        .kind_pdc       (kind_pdc),
        .taken_pdc      (taken_pdc),
        .npc_pdc        (npc_pdc),
        .choice_btb_ras (choice_btb_ras)
    );

    bind npc_predictor npc_predictor_properties #(
        .gh_width   (gh_width),
        .addr_width (addr_width)
    ) props (
        .clk            (clk),
        .reset          (reset),
        .kind_ex        (kind_ex),
        .pc             (pc),
        .pc_hashed      (pc_hashed),
        .kind_pdc       (kind_pdc),
        .taken_pdc      (taken_pdc),
        .npc_pdc        (npc_pdc),
        .choice_btb_ras (choice_btb_ras)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((reset_cycles + directed_steps + random_steps + 20) * clk_period);
        $display("Watchdog expired before the tests finished.");
        $display(">>> FAIL");
        $fatal(1);
    end

    // *************************************************************************
    // Stimulus and reference model.
    // *************************************************************************

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [addr_width-1:0] expected_npc(
        input logic [addr_width-1:0] lpc,
        input logic [gh_width-1:0]   hash,
        input logic [2:0]            kind,
        input logic                  taken
    );
        logic [addr_width-1:0] seq;
        seq = lpc + 1'b1;
        if (!taken || kind == npc_pkg::NOT_JUMP || kind == 3'd7) begin
            return seq;
        end
        if (kind == npc_pkg::RET && model_ctr[hash] >= 2) begin
            return (model_stack.size() > 0) ? model_stack[$] : seq;  // RAS chosen.
        end
        return model_vld[hash] ? model_tgt[hash] : seq;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < entries; i++) begin
            model_vld[i] = 1'b0;
            model_ctr[i] = npc_pkg::CHOICE_RESET;
        end
        model_stack.delete();
    endtask

    task automatic update_model();
        if (kind_ex != npc_pkg::NOT_JUMP && kind_ex != 3'd7) begin
            model_tgt[hashed_ex] = npc_ex;
            model_vld[hashed_ex] = 1'b1;
        end
        if (kind_ex == npc_pkg::CALL) begin
            model_stack.push_back(addr_width'(pc_ex + 1'b1));
            if (model_stack.size() > stack_len) begin
                void'(model_stack.pop_front());  // Oldest lost.
            end
        end else if (kind_ex == npc_pkg::RET) begin
            if (model_stack.size() > 0) begin
                void'(model_stack.pop_back());
            end
            if (choice_real && model_ctr[hashed_ex] < 3) begin
                model_ctr[hashed_ex]++;
            end else if (!choice_real && model_ctr[hashed_ex] > 0) begin
                model_ctr[hashed_ex]--;
            end
        end
    endtask

    task automatic check_outputs();
        logic [addr_width-1:0] exp_npc;
        logic                  exp_choice;
        exp_npc    = expected_npc(pc, pc_hashed, kind_pdc, taken_pdc);
        exp_choice = (model_ctr[pc_hashed] >= 2);
        assert (npc_pdc === exp_npc) else begin
            $display("Error at %0t ns: npc_pdc expected %h, got %h", $time, exp_npc, npc_pdc);
            $display(">>> FAIL");
            $fatal(1);
        end
        assert (choice_btb_ras === exp_choice) else begin
            $display("Error at %0t ns: choice_btb_ras expected %b, got %b",
                     $time, exp_choice, choice_btb_ras);
            $display(">>> FAIL");
            $fatal(1);
        end
        assert (dut.props.fail_count == 0) else begin
            $display("A bound property of the predictor failed before %0t ns.", $time);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    // Drive on the rising edge and check in mid cycle.
    task automatic step(
        input logic [2:0]            kind_e,
        input logic [addr_width-1:0] pc_e,
        input logic [addr_width-1:0] npc_e,
        input logic [gh_width-1:0]   hash_e,
        input logic                  ras_right,
        input logic [addr_width-1:0] pc_l,
        input logic [gh_width-1:0]   hash_l,
        input logic [2:0]            kind_l,
        input logic                  taken_l
    );
        @(posedge clk);
        kind_ex     <= kind_e;
        pc_ex       <= pc_e;
        npc_ex      <= npc_e;
        hashed_ex   <= hash_e;
        choice_real <= ras_right;
        pc          <= pc_l;
        pc_hashed   <= hash_l;
        kind_pdc    <= kind_l;
        taken_pdc   <= taken_l;
        @(negedge clk);
        check_outputs();
        update_model();
    endtask

    task automatic resolve(
        input logic [2:0]            kind_e,
        input logic [addr_width-1:0] pc_e,
        input logic [addr_width-1:0] npc_e,
        input logic [gh_width-1:0]   hash_e,
        input logic                  ras_right
    );
        step(kind_e, pc_e, npc_e, hash_e, ras_right, 16'h0040, 4'd0, npc_pkg::NOT_JUMP, 1'b0);
    endtask

    task automatic lookup(
        input logic [addr_width-1:0] pc_l,
        input logic [gh_width-1:0]   hash_l,
        input logic [2:0]            kind_l
    );
        step(npc_pkg::NOT_JUMP, '0, '0, '0, 1'b0, pc_l, hash_l, kind_l, 1'b1);
    endtask

    // *************************************************************************
    // Test sequence.
    // *************************************************************************

    initial begin
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        rng_state   = 32'h44b57598;
        reset       = 1'b1;
        pc_ex       = '0;
        npc_ex      = '0;
        hashed_ex   = '0;
        kind_ex     = npc_pkg::NOT_JUMP;
        choice_real = 1'b0;
        pc          = '0;
        pc_hashed   = '0;
        kind_pdc    = npc_pkg::NOT_JUMP;
        taken_pdc   = 1'b0;
        clear_model();

        // Taken lookups across the tables while reset holds.
        for (int i = 0; i < reset_cycles; i++) begin
            @(posedge clk);
            pc        <= 16'h0500 + 16'(i);
            pc_hashed <= gh_width'(i);
            kind_pdc  <= (i % 2 == 0) ? npc_pkg::DIRECT_JUMP : npc_pkg::RET;
            taken_pdc <= 1'b1;
        end
        reset <= 1'b0;

        // BTB target seen by direct, call and jump lookups.
        resolve(npc_pkg::DIRECT_JUMP, 16'h0100, 16'h1234, 4'd5, 1'b0);
        lookup(16'h0400, 4'd5, npc_pkg::DIRECT_JUMP);
        lookup(16'h0410, 4'd5, npc_pkg::CALL);
        lookup(16'h0420, 4'd5, npc_pkg::JUMP);

        // Three calls and two returns train hash 9 toward the RAS.
        for (int i = 0; i < 3; i++) begin
            resolve(npc_pkg::CALL, 16'h0200 + 16'(i * 16), 16'h0800, 4'd3, 1'b0);
        end
        resolve(npc_pkg::RET, 16'h0900, 16'h0220, 4'd9, 1'b1);
        resolve(npc_pkg::RET, 16'h0910, 16'h0210, 4'd9, 1'b1);
        lookup(16'h0920, 4'd9, npc_pkg::RET);

        // Five calls into four entries and a drain past empty.
        for (int i = 0; i < 5; i++) begin
            resolve(npc_pkg::CALL, 16'h0300 + 16'(i * 16), 16'h0800, 4'd3, 1'b0);
        end
        for (int i = 0; i < 6; i++) begin
            step(npc_pkg::RET, 16'h0a00, 16'h0b00, 4'd9, 1'b1,
                 16'h0c00 + 16'(i), 4'd9, npc_pkg::RET, 1'b1);
        end
        lookup(16'h0d00, 4'd3, npc_pkg::RET);  // BTB side.

        // Counter pinned at zero needs two steps back.
        for (int i = 0; i < 4; i++) begin
            resolve(npc_pkg::RET, 16'h0e00, 16'h0f00, 4'd12, 1'b0);
        end
        resolve(npc_pkg::RET, 16'h0e00, 16'h0f00, 4'd12, 1'b1);
        lookup(16'h0e40, 4'd12, npc_pkg::RET);

        for (int n = 0; n < random_steps; n++) begin
            r0 = next_rand();
            r1 = next_rand();
            r2 = next_rand();
            step(r0[31:29], r0[23:8], r1[31:16], r0[28:25], r0[24],
                 r2[31:16], r1[15:12], r1[11:9], |r1[8:7]);
        end

        @(posedge clk);
        @(negedge clk);
        if (dut.props.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1);
        end
    end

endmodule

// ==== flist.f ====
source/npc_pkg.sv
source/ex_update_if.sv
source/btb.sv
source/ras.sv
source/cpht.sv
source/npc_select.sv
source/npc_predictor.sv
sim/npc_predictor_properties.sv
sim/npc_predictor_tb.sv

// ==== Bender.yml ====
package:
  name: npc_predictor

sources:
  - files:
      - source/npc_pkg.sv
      - source/ex_update_if.sv
      - source/btb.sv
      - source/ras.sv
      - source/cpht.sv
      - source/npc_select.sv
      - source/npc_predictor.sv
  - target: simulation
    files:
      - sim/npc_predictor_properties.sv
      - sim/npc_predictor_tb.sv
